//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps
TOP       ?= tb_icache
DUT_TOP   ?= icache_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SRCS      := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS  := $(filter-out tb_%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) icache_consts.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+. --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+.
icache_pkg.sv
icache_lookup.sv
icache_miss_handler.sv
icache_bypass.sv
icache_refill.sv
icache_top.sv
tb_clock_gen.sv
tb_icache.sv

//--- icache_bypass.sv
/*
 * Uncached fetch path.
 * One FSM per port, a round-robin request arbiter and a FIFO that
 * remembers which port each outstanding memory read belongs to.
 */

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_bypass (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic [`ICACHE_NR_PORTS-1:0][`ICACHE_AW-1:0]  in_addr_i,
  input  logic [`ICACHE_NR_PORTS-1:0]                  in_valid_i,
  output logic [`ICACHE_NR_PORTS-1:0]                  in_ready_o,
  output logic [`ICACHE_NR_PORTS-1:0][`ICACHE_DW-1:0]  in_data_o,
  output logic [`ICACHE_NR_PORTS-1:0]                  in_error_o,
  output icache_pkg::refill_req_t                      refill_req_o,
  output logic                                         refill_req_valid_o,
  input  logic                                         refill_req_ready_i,
  input  icache_pkg::refill_rsp_t                      refill_rsp_i,
  input  logic                                         refill_rsp_valid_i
);

  localparam int PtrW = $clog2(`ICACHE_BYP_FIFO_DEPTH);

  logic [`ICACHE_NR_PORTS-1:0] arb_req, grant, last_q, rsp_hit;
  logic [`ICACHE_NR_PORTS-1:0] fifo_q [`ICACHE_BYP_FIFO_DEPTH];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0] count_q;
  logic fifo_full, push, pop;
  logic [`ICACHE_AW-1:0] sel_addr;

  assign fifo_full = (count_q == (PtrW+1)'(`ICACHE_BYP_FIFO_DEPTH));
  assign grant = icache_pkg::rr_grant(arb_req, last_q);
  assign push = refill_req_valid_o && refill_req_ready_i;
  assign pop = refill_rsp_valid_i;
  // Answers arrive in request order, so the FIFO head owns each one
  assign rsp_hit = fifo_q[rd_ptr_q] & {`ICACHE_NR_PORTS{refill_rsp_valid_i}};

  always_comb begin
    sel_addr = in_addr_i[0];
    for (int i = 0; i < `ICACHE_NR_PORTS; i++) begin
      if (grant[i]) begin
        sel_addr = in_addr_i[i];
      end
    end
  end

  assign refill_req_valid_o = |arb_req;
  assign refill_req_o.addr = {sel_addr[`ICACHE_AW-1:`ICACHE_LINE_ALIGN],
                              {`ICACHE_LINE_ALIGN{1'b0}}};
  assign refill_req_o.bypass = 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        last_q <= grant;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= grant;
    end
  end

  for (genvar i = 0; i < `ICACHE_NR_PORTS; i++) begin : gen_port
    icache_pkg::bypass_state_e state_q, state_d;
    logic [`ICACHE_LINE_ALIGN-`ICACHE_FETCH_ALIGN-1:0] offset;

    assign offset = in_addr_i[i][`ICACHE_LINE_ALIGN-1:`ICACHE_FETCH_ALIGN];
    assign arb_req[i] = (state_q == icache_pkg::RequestData) && !fifo_full;
    assign in_ready_o[i] = (state_q == icache_pkg::PresentResponse);

    always_comb begin
      state_d = state_q;
      unique case (state_q)
        icache_pkg::BypassIdle: if (in_valid_i[i]) state_d = icache_pkg::RequestData;
        icache_pkg::RequestData: if (push && grant[i]) state_d = icache_pkg::WaitResponse;
        icache_pkg::WaitResponse: if (rsp_hit[i]) state_d = icache_pkg::PresentResponse;
        default: state_d = icache_pkg::BypassIdle;
      endcase
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        state_q <= icache_pkg::BypassIdle;
      end else begin
        state_q <= state_d;
      end
    end

    // Word is kept for the single PresentResponse cycle
    always_ff @(posedge clk_i) begin
      if (rsp_hit[i]) begin
        in_data_o[i] <= refill_rsp_i.data[offset*`ICACHE_DW +: `ICACHE_DW];
        in_error_o[i] <= refill_rsp_i.error;
      end
    end
  end

endmodule

//--- icache_consts.svh
/*
 * Instruction cache constants.
 * Port count, address and data widths, line geometry and bypass FIFO depth.
 */

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

`define ICACHE_NR_PORTS 2
`define ICACHE_AW 32
`define ICACHE_DW 32

`define ICACHE_LINE_W 128
`define ICACHE_LINE_COUNT 16
`define ICACHE_LINE_ALIGN 4
`define ICACHE_FETCH_ALIGN 2
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W 24

`define ICACHE_BYP_FIFO_DEPTH 4

`endif

//--- icache_lookup.sv
/*
 * Direct-mapped cache lookup.
 * Arbitrates the fetch ports round-robin, holds the tag, valid, error and
 * data arrays, and applies flushes and line writes.
 */

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  icache_pkg::fetch_req_t [`ICACHE_NR_PORTS-1:0] req_i,
  input  logic [`ICACHE_NR_PORTS-1:0]                   req_valid_i,
  output logic [`ICACHE_NR_PORTS-1:0]                   req_ready_o,
  input  logic                                          flush_valid_i,
  output logic                                          flush_ready_o,
  output icache_pkg::lookup_rsp_t                       rsp_o,
  output logic                                          rsp_valid_o,
  input  logic                                          rsp_ready_i,
  input  icache_pkg::line_write_t                       write_i,
  input  logic                                          write_valid_i
);

  logic [`ICACHE_NR_PORTS-1:0] grant, last_q;
  icache_pkg::fetch_req_t sel_req, req_q;
  logic rsp_valid_q, flush_ready_q, accept, flush_take;
  logic [`ICACHE_LINE_COUNT-1:0] valid_q, err_q;
  logic [`ICACHE_TAG_W-1:0] tag_q [`ICACHE_LINE_COUNT];
  logic [`ICACHE_LINE_W-1:0] data_q [`ICACHE_LINE_COUNT];
  logic [`ICACHE_INDEX_W-1:0] rd_index;

  assign grant = icache_pkg::rr_grant(req_valid_i, last_q);

  always_comb begin
    sel_req = req_i[0];
    for (int i = 0; i < `ICACHE_NR_PORTS; i++) begin
      if (grant[i]) begin
        sel_req = req_i[i];
      end
    end
  end

  // A pending flush blocks new lookups, and it waits until the output is empty
  assign accept = (!rsp_valid_q || rsp_ready_i) && !flush_valid_i;
  assign req_ready_o = grant & {`ICACHE_NR_PORTS{accept}};
  assign flush_take = flush_valid_i && !rsp_valid_q && !flush_ready_q;
  assign flush_ready_o = flush_ready_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      last_q <= '0;
      flush_ready_q <= 1'b0;
      valid_q <= '0;
    end else begin
      flush_ready_q <= flush_take;
      if (accept) begin
        rsp_valid_q <= |req_valid_i;
        if (|req_valid_i) begin
          last_q <= grant;
        end
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (flush_take) begin
        valid_q <= '0;
      end else if (write_valid_i) begin
        valid_q[write_i.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && |req_valid_i) begin
      req_q <= sel_req;
    end
    if (write_valid_i) begin
      tag_q[write_i.index] <= write_i.tag;
      data_q[write_i.index] <= write_i.data;
      err_q[write_i.index] <= write_i.error;
    end
  end

  // Compare against the arrays as they stand now, so a line written just
  // before is seen by the request behind it
  assign rd_index = req_q.addr[`ICACHE_LINE_ALIGN +: `ICACHE_INDEX_W];
  assign rsp_o.addr = req_q.addr;
  assign rsp_o.id = req_q.id;
  assign rsp_o.hit = valid_q[rd_index]
                   && (tag_q[rd_index] == req_q.addr[`ICACHE_AW-1 -: `ICACHE_TAG_W]);
  assign rsp_o.data = data_q[rd_index];
  assign rsp_o.error = err_q[rd_index];
  assign rsp_valid_o = rsp_valid_q;

endmodule

//--- icache_miss_handler.sv
/*
 * Miss handler.
 * Answers hits from the looked-up line and refills missing lines,
 * writing them into the cache before answering the fetch port.
 */

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_miss_handler (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  icache_pkg::lookup_rsp_t            lookup_i,
  input  logic                               lookup_valid_i,
  output logic                               lookup_ready_o,
  output icache_pkg::line_write_t            write_o,
  output logic                               write_valid_o,
  output icache_pkg::refill_req_t            refill_req_o,
  output logic                               refill_req_valid_o,
  input  logic                               refill_req_ready_i,
  input  icache_pkg::refill_rsp_t            refill_rsp_i,
  input  logic                               refill_rsp_valid_i,
  output logic [`ICACHE_DW-1:0]              fetch_data_o,
  output logic                               fetch_error_o,
  output logic [`ICACHE_NR_PORTS-1:0]        fetch_id_o,
  output logic                               fetch_valid_o
);

  icache_pkg::handler_state_e state_q, state_d;
  logic req_sent_q, line_err_q, word_err_q, take;
  logic [`ICACHE_LINE_W-1:0] line_q, line_src;
  logic [`ICACHE_DW-1:0] word, word_q;
  logic [`ICACHE_NR_PORTS-1:0] id_q;
  logic [`ICACHE_LINE_ALIGN-`ICACHE_FETCH_ALIGN-1:0] offset;

  // The lookup result stays held during a miss, so its address is used directly
  assign offset = lookup_i.addr[`ICACHE_LINE_ALIGN-1:`ICACHE_FETCH_ALIGN];
  assign line_src = (state_q == icache_pkg::HandlerIdle) ? lookup_i.data : line_q;
  assign word = line_src[offset*`ICACHE_DW +: `ICACHE_DW];

  always_comb begin
    state_d = state_q;
    lookup_ready_o = 1'b0;
    write_valid_o = 1'b0;
    refill_req_valid_o = 1'b0;
    unique case (state_q)
      icache_pkg::HandlerIdle: begin
        if (lookup_valid_i) begin
          lookup_ready_o = lookup_i.hit;
          state_d = lookup_i.hit ? icache_pkg::Respond : icache_pkg::Refill;
        end
      end
      icache_pkg::Refill: begin
        refill_req_valid_o = !req_sent_q;
        if (refill_rsp_valid_i) begin
          state_d = icache_pkg::WriteLine;
        end
      end
      icache_pkg::WriteLine: begin
        write_valid_o = 1'b1;
        lookup_ready_o = 1'b1;
        state_d = icache_pkg::Respond;
      end
      default: state_d = icache_pkg::HandlerIdle;
    endcase
  end

  assign take = lookup_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= icache_pkg::HandlerIdle;
      req_sent_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (refill_req_valid_o && refill_req_ready_i) begin
        req_sent_q <= 1'b1;
      end else if (refill_rsp_valid_i) begin
        req_sent_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_rsp_valid_i) begin
      line_q <= refill_rsp_i.data;
      line_err_q <= refill_rsp_i.error;
    end
    if (take) begin
      word_q <= word;
      word_err_q <= (state_q == icache_pkg::HandlerIdle) ? lookup_i.error : line_err_q;
      id_q <= lookup_i.id;
    end
  end

  assign refill_req_o.addr = {lookup_i.addr[`ICACHE_AW-1:`ICACHE_LINE_ALIGN],
                              {`ICACHE_LINE_ALIGN{1'b0}}};
  assign refill_req_o.bypass = 1'b0;
  assign write_o.index = lookup_i.addr[`ICACHE_LINE_ALIGN +: `ICACHE_INDEX_W];
  assign write_o.tag = lookup_i.addr[`ICACHE_AW-1 -: `ICACHE_TAG_W];
  assign write_o.data = line_q;
  assign write_o.error = line_err_q;

  assign fetch_data_o = word_q;
  assign fetch_error_o = word_err_q;
  assign fetch_id_o = id_q;
  assign fetch_valid_o = (state_q == icache_pkg::Respond);

endmodule

//--- icache_pkg.sv
/*
 * Instruction cache package.
 * Request, response and line-write structs, FSM state enums and the
 * round-robin grant shared by the fetch port arbiters.
 */

`include "icache_consts.svh"

package icache_pkg;

  typedef struct packed {
    logic [`ICACHE_AW-1:0]       addr;
    logic [`ICACHE_NR_PORTS-1:0] id;
  } fetch_req_t;

  typedef struct packed {
    logic [`ICACHE_AW-1:0]       addr;
    logic [`ICACHE_NR_PORTS-1:0] id;
    logic                        hit;
    logic [`ICACHE_LINE_W-1:0]   data;
    logic                        error;
  } lookup_rsp_t;

  typedef struct packed {
    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_LINE_W-1:0]  data;
    logic                       error;
  } line_write_t;

  typedef struct packed {
    logic [`ICACHE_AW-1:0] addr;
    logic                  bypass;
  } refill_req_t;

  typedef struct packed {
    logic [`ICACHE_LINE_W-1:0] data;
    logic                      error;
    logic                      bypass;
  } refill_rsp_t;

  typedef struct packed {
    logic [`ICACHE_AW-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [`ICACHE_LINE_W-1:0] data;
    logic                      error;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    BypassIdle, RequestData, WaitResponse, PresentResponse
  } bypass_state_e;

  typedef enum logic [1:0] {
    HandlerIdle, Refill, WriteLine, Respond
  } handler_state_e;

  // Search starts one past the last grant, so every requester gets its turn
  function automatic logic [`ICACHE_NR_PORTS-1:0] rr_grant(
    input logic [`ICACHE_NR_PORTS-1:0] req,
    input logic [`ICACHE_NR_PORTS-1:0] last
  );
    logic [`ICACHE_NR_PORTS-1:0] gnt;
    int start;
    int idx;
    gnt = '0;
    start = 0;
    for (int k = 0; k < `ICACHE_NR_PORTS; k++) begin
      if (last[k]) begin
        start = k + 1;
      end
    end
    for (int k = 0; k < `ICACHE_NR_PORTS; k++) begin
      idx = (start + k) % `ICACHE_NR_PORTS;
      if (req[idx] && gnt == '0) begin
        gnt[idx] = 1'b1;
      end
    end
    return gnt;
  endfunction

endpackage

//--- icache_refill.sv
/*
 * Refill unit.
 * Arbitrates the miss handler and bypass requests, keeps one memory read
 * in flight and routes the answer back by its bypass bit.
 */

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  icache_pkg::refill_req_t  handler_req_i,
  input  logic                     handler_valid_i,
  output logic                     handler_ready_o,
  input  icache_pkg::refill_req_t  bypass_req_i,
  input  logic                     bypass_valid_i,
  output logic                     bypass_ready_o,
  output icache_pkg::refill_rsp_t  handler_rsp_o,
  output logic                     handler_rsp_valid_o,
  output icache_pkg::refill_rsp_t  bypass_rsp_o,
  output logic                     bypass_rsp_valid_o,
  output icache_pkg::mem_req_t     mem_req_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  input  icache_pkg::mem_rsp_t     mem_rsp_i,
  input  logic                     mem_rsp_valid_i
);

  logic req_pend_q, wait_q, byp_q, last_byp_q;
  logic idle, pick_byp, take;
  logic [`ICACHE_AW-1:0] addr_q;
  icache_pkg::refill_rsp_t rsp;

  assign idle = !req_pend_q && !wait_q;
  // On contention the side that did not win last time goes first
  assign pick_byp = bypass_valid_i && (!handler_valid_i || !last_byp_q);
  assign handler_ready_o = idle && handler_valid_i && !pick_byp;
  assign bypass_ready_o = idle && pick_byp;
  assign take = handler_ready_o || bypass_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_pend_q <= 1'b0;
      wait_q <= 1'b0;
      last_byp_q <= 1'b0;
      byp_q <= 1'b0;
    end else begin
      if (take) begin
        req_pend_q <= 1'b1;
        byp_q <= pick_byp;
        last_byp_q <= pick_byp;
      end else if (req_pend_q && mem_req_ready_i) begin
        req_pend_q <= 1'b0;
        wait_q <= 1'b1;
      end else if (wait_q && mem_rsp_valid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q <= pick_byp ? bypass_req_i.addr : handler_req_i.addr;
    end
  end

  assign mem_req_o.addr = addr_q;
  assign mem_req_valid_o = req_pend_q;

  assign rsp.data = mem_rsp_i.data;
  assign rsp.error = mem_rsp_i.error;
  assign rsp.bypass = byp_q;
  assign handler_rsp_o = rsp;
  assign bypass_rsp_o = rsp;
  assign handler_rsp_valid_o = mem_rsp_valid_i && wait_q && !byp_q;
  assign bypass_rsp_valid_o = mem_rsp_valid_i && wait_q && byp_q;

endmodule

//--- icache_top.sv
/*
 * Two-port instruction cache top level.
 * Splits fetches into the cached and bypass paths, merges their answers
 * and shares a single refill port to memory.
 */

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic [`ICACHE_NR_PORTS-1:0][`ICACHE_AW-1:0]  inst_addr_i,
  input  logic [`ICACHE_NR_PORTS-1:0]                  inst_cacheable_i,
  input  logic [`ICACHE_NR_PORTS-1:0]                  inst_valid_i,
  output logic [`ICACHE_NR_PORTS-1:0][`ICACHE_DW-1:0]  inst_data_o,
  output logic [`ICACHE_NR_PORTS-1:0]                  inst_ready_o,
  output logic [`ICACHE_NR_PORTS-1:0]                  inst_error_o,
  input  logic [`ICACHE_NR_PORTS-1:0]                  flush_valid_i,
  output logic [`ICACHE_NR_PORTS-1:0]                  flush_ready_o,
  output icache_pkg::mem_req_t                         mem_req_o,
  output logic                                         mem_req_valid_o,
  input  logic                                         mem_req_ready_i,
  input  icache_pkg::mem_rsp_t                         mem_rsp_i,
  input  logic                                         mem_rsp_valid_i
);

  icache_pkg::fetch_req_t [`ICACHE_NR_PORTS-1:0] fetch_req;
  logic [`ICACHE_NR_PORTS-1:0] cache_valid, cache_ready, cache_pend_q;
  logic [`ICACHE_NR_PORTS-1:0] byp_valid, byp_ready, byp_error;
  logic [`ICACHE_NR_PORTS-1:0][`ICACHE_DW-1:0] byp_data;
  logic [`ICACHE_NR_PORTS-1:0] fetch_id;
  logic [`ICACHE_DW-1:0] fetch_data;
  logic fetch_error, fetch_valid, flush_ready;
  icache_pkg::lookup_rsp_t lookup_rsp;
  logic lookup_valid, lookup_ready;
  icache_pkg::line_write_t line_write;
  logic line_write_valid;
  icache_pkg::refill_req_t handler_req, bypass_req;
  logic handler_req_valid, handler_req_ready, bypass_req_valid, bypass_req_ready;
  icache_pkg::refill_rsp_t handler_rsp, bypass_rsp;
  logic handler_rsp_valid, bypass_rsp_valid;

  for (genvar i = 0; i < `ICACHE_NR_PORTS; i++) begin : gen_port
    // A port already handed to the lookup stays out until its answer returns
    assign cache_valid[i] = inst_valid_i[i] & inst_cacheable_i[i] & ~cache_pend_q[i];
    assign byp_valid[i] = inst_valid_i[i] & ~inst_cacheable_i[i];
    assign fetch_req[i].addr = inst_addr_i[i];
    assign fetch_req[i].id = `ICACHE_NR_PORTS'(1) << i;

    assign inst_ready_o[i] = inst_cacheable_i[i] ? (fetch_valid & fetch_id[i]) : byp_ready[i];
    assign inst_data_o[i] = inst_cacheable_i[i] ? fetch_data : byp_data[i];
    assign inst_error_o[i] = inst_cacheable_i[i] ? fetch_error : byp_error[i];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cache_pend_q[i] <= 1'b0;
      end else if (cache_valid[i] && cache_ready[i]) begin
        cache_pend_q[i] <= 1'b1;
      end else if (fetch_valid && fetch_id[i]) begin
        cache_pend_q[i] <= 1'b0;
      end
    end
  end

  assign flush_ready_o = {`ICACHE_NR_PORTS{flush_ready}};

  icache_lookup i_lookup (
    .clk_i, .rst_i,
    .req_i         (fetch_req),
    .req_valid_i   (cache_valid),
    .req_ready_o   (cache_ready),
    .flush_valid_i (|flush_valid_i),
    .flush_ready_o (flush_ready),
    .rsp_o         (lookup_rsp),
    .rsp_valid_o   (lookup_valid),
    .rsp_ready_i   (lookup_ready),
    .write_i       (line_write),
    .write_valid_i (line_write_valid)
  );

  icache_miss_handler i_handler (
    .clk_i, .rst_i,
    .lookup_i           (lookup_rsp),
    .lookup_valid_i     (lookup_valid),
    .lookup_ready_o     (lookup_ready),
    .write_o            (line_write),
    .write_valid_o      (line_write_valid),
    .refill_req_o       (handler_req),
    .refill_req_valid_o (handler_req_valid),
    .refill_req_ready_i (handler_req_ready),
    .refill_rsp_i       (handler_rsp),
    .refill_rsp_valid_i (handler_rsp_valid),
    .fetch_data_o       (fetch_data),
    .fetch_error_o      (fetch_error),
    .fetch_id_o         (fetch_id),
    .fetch_valid_o      (fetch_valid)
  );

  icache_bypass i_bypass (
    .clk_i, .rst_i,
    .in_addr_i          (inst_addr_i),
    .in_valid_i         (byp_valid),
    .in_ready_o         (byp_ready),
    .in_data_o          (byp_data),
    .in_error_o         (byp_error),
    .refill_req_o       (bypass_req),
    .refill_req_valid_o (bypass_req_valid),
    .refill_req_ready_i (bypass_req_ready),
    .refill_rsp_i       (bypass_rsp),
    .refill_rsp_valid_i (bypass_rsp_valid)
  );

  icache_refill i_refill (
    .clk_i, .rst_i,
    .handler_req_i       (handler_req),
    .handler_valid_i     (handler_req_valid),
    .handler_ready_o     (handler_req_ready),
    .bypass_req_i        (bypass_req),
    .bypass_valid_i      (bypass_req_valid),
    .bypass_ready_o      (bypass_req_ready),
    .handler_rsp_o       (handler_rsp),
    .handler_rsp_valid_o (handler_rsp_valid),
    .bypass_rsp_o        (bypass_rsp),
    .bypass_rsp_valid_o  (bypass_rsp_valid),
    .mem_req_o, .mem_req_valid_o, .mem_req_ready_i,
    .mem_rsp_i, .mem_rsp_valid_i
  );

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset generator.
 * 20 ns clock, reset high for the first 10 rising edges.
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- tb_icache.sv
/*
 * Instruction cache testbench.
 * Drives both fetch ports, models a line-wide memory with random stalls
 * and checks every answer with assertions.
 */

`timescale 1ns/1ps
`include "icache_consts.svh"

module tb_icache;

  localparam logic [31:0] ICACHE_TB_PATTERN = 32'ha5c3_5a3c;
  localparam int NUM_TESTS = 6;
  localparam int TEST_MAX_CYCLES = 800;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_MAX_CYCLES + 200;
  localparam int NP = `ICACHE_NR_PORTS;

  logic clk_i, rst_i;
  logic [NP-1:0][`ICACHE_AW-1:0] inst_addr_i;
  logic [NP-1:0] inst_cacheable_i, inst_valid_i, inst_ready_o, inst_error_o;
  logic [NP-1:0][`ICACHE_DW-1:0] inst_data_o;
  logic [NP-1:0] flush_valid_i, flush_ready_o;
  icache_pkg::mem_req_t mem_req_o;
  icache_pkg::mem_rsp_t mem_rsp_i;
  logic mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i;

  logic [31:0] lfsr_q = 32'h3472_f276;
  logic [31:0] exp_data [NP];
  logic [NP-1:0] exp_err, busy;
  logic idle_check;
  int err_count = 0;
  int mem_req_count = 0;
  int answer_count = 0;
  int fetch_count, test_num, test_err_base, cycles;

  tb_clock_gen clock_gen_i (.clk_o(clk_i), .rst_o(rst_i));

  icache_top icache_top_i (
    .clk_i, .rst_i,
    .inst_addr_i, .inst_cacheable_i, .inst_valid_i,
    .inst_data_o, .inst_ready_o, .inst_error_o,
    .flush_valid_i, .flush_ready_o,
    .mem_req_o, .mem_req_valid_o, .mem_req_ready_i,
    .mem_rsp_i, .mem_rsp_valid_i
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Each word holds its own byte address XOR the pattern
  function automatic logic [31:0] model_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ ICACHE_TB_PATTERN;
  endfunction

  function automatic logic [`ICACHE_LINE_W-1:0] line_words(input logic [31:0] a);
    logic [`ICACHE_LINE_W-1:0] line;
    for (int k = 0; k < `ICACHE_LINE_W / 32; k++) begin
      line[k*32 +: 32] = model_word(a + 32'(4 * k));
    end
    return line;
  endfunction

  // The memory serves one transaction at a time with random accept and answer delay
  initial begin : memory_model
    logic [31:0] pend_addr;
    logic pend;
    int delay;
    pend = 1'b0;
    pend_addr = '0;
    delay = 0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i = '0;
    forever begin
      @(negedge clk_i);
      mem_rsp_valid_i = 1'b0;
      if (pend) begin
        if (delay == 0) begin
          mem_rsp_i.data = line_words(pend_addr);
          mem_rsp_i.error = (pend_addr[31:28] == 4'hf);
          mem_rsp_valid_i = 1'b1;
          pend = 1'b0;
        end else begin
          delay--;
        end
      end
      mem_req_ready_i = (random_bits(2) != 0);
      if (mem_req_valid_o && mem_req_ready_i && !pend) begin
        pend = 1'b1;
        pend_addr = mem_req_o.addr;
        delay = int'(random_bits(2));
        mem_req_count++;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    idle_check |-> (inst_ready_o == '0 && !mem_req_valid_o && flush_ready_o == '0))
  else begin
    $display("[FAIL] %0t: DUT output active before any request", $time);
    err_count++;
  end

  for (genvar p = 0; p < NP; p++) begin : gen_check
    assert property (@(posedge clk_i) disable iff (rst_i) inst_ready_o[p] |-> busy[p])
    else begin
      $display("[FAIL] %0t: port %0d answered with no fetch pending", $time, p);
      err_count++;
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
      inst_ready_o[p] |-> (inst_data_o[p] == exp_data[p] && inst_error_o[p] == exp_err[p]))
    else begin
      $display("[FAIL] %0t: port %0d got %h err %b, expected %h err %b", $time, p,
               inst_data_o[p], inst_error_o[p], exp_data[p], exp_err[p]);
      err_count++;
    end
  end

  // Every answer pulse is counted apart from the fetch tasks
  always @(posedge clk_i) begin
    if (!rst_i) begin
      answer_count <= answer_count + $countones(inst_ready_o);
    end
  end

  // Called on a falling edge; returns on the falling edge after the answer
  task automatic fetch_and_wait(input int p, input logic [31:0] addr, input logic cacheable);
    exp_data[p] = model_word(addr);
    exp_err[p] = (addr[31:28] == 4'hf);
    busy[p] = 1'b1;
    inst_addr_i[p] = addr;
    inst_cacheable_i[p] = cacheable;
    inst_valid_i[p] = 1'b1;
    do @(negedge clk_i); while (!inst_ready_o[p]);
    @(negedge clk_i);
    inst_valid_i[p] = 1'b0;
    busy[p] = 1'b0;
    fetch_count++;
  endtask

  task automatic flush_lines();
    flush_valid_i[0] = 1'b1;
    do @(negedge clk_i); while (!flush_ready_o[0]);
    assert (flush_ready_o == '1) else begin
      $display("[FAIL] %0t: flush_ready_o %b not set on all ports", $time, flush_ready_o);
      err_count++;
    end
    flush_valid_i[0] = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic check_requests(input int base, input int expected, input string what);
    assert (mem_req_count - base == expected) else begin
      $display("[FAIL] %0t: %s made %0d memory requests, expected %0d", $time, what,
               mem_req_count - base, expected);
      err_count++;
    end
  endtask

  task automatic random_fetches(input int p, input int n);
    logic [31:0] addr;
    logic cacheable;
    for (int k = 0; k < n; k++) begin
      addr = 32'h0000_3000 | (random_bits(8) << 2);
      if (random_bits(3) == 0) begin
        addr[31:28] = 4'hf;
      end
      cacheable = random_bits(1) != 0;
      fetch_and_wait(p, addr, cacheable);
    end
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("Test %0d %s: %s", test_num, name, (err_count == test_err_base) ? "ok" : "errors");
    test_err_base = err_count;
  endtask

  initial begin : timeout_watch
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    int base;
    inst_addr_i = '0;
    inst_cacheable_i = '0;
    inst_valid_i = '0;
    flush_valid_i = '0;
    busy = '0;
    exp_err = '0;
    exp_data[0] = '0;
    exp_data[1] = '0;
    idle_check = 1'b0;
    fetch_count = 0;
    test_num = 0;
    test_err_base = 0;
    wait (!rst_i);
    @(negedge clk_i);

    idle_check = 1'b1;
    repeat (20) @(negedge clk_i);
    idle_check = 1'b0;
    report_test("reset state");

    base = mem_req_count;
    fetch_and_wait(0, 32'h0000_1000, 1'b1);
    check_requests(base, 1, "first fetch to a line");
    base = mem_req_count;
    fetch_and_wait(0, 32'h0000_1004, 1'b1);
    fetch_and_wait(1, 32'h0000_1008, 1'b1);
    fetch_and_wait(0, 32'h0000_100c, 1'b1);
    check_requests(base, 0, "hits in a cached line");
    report_test("cached line fill and hits");

    base = mem_req_count;
    fetch_and_wait(1, 32'h0000_2000, 1'b0);
    fetch_and_wait(1, 32'h0000_2000, 1'b0);
    fetch_and_wait(0, 32'h0000_2004, 1'b0);
    check_requests(base, 3, "non-cacheable fetches");
    report_test("bypass fetches");

    base = mem_req_count;
    fetch_and_wait(0, 32'hf000_0040, 1'b1);
    fetch_and_wait(1, 32'hf000_0044, 1'b1);
    check_requests(base, 1, "cached error line");
    fetch_and_wait(1, 32'hf000_1008, 1'b0);
    check_requests(base, 2, "bypass error fetch");
    report_test("memory errors");

    flush_lines();
    base = mem_req_count;
    fetch_and_wait(0, 32'h0000_1008, 1'b1);
    check_requests(base, 1, "fetch after flush");
    base = mem_req_count;
    fetch_and_wait(1, 32'h0000_100c, 1'b1);
    check_requests(base, 0, "hit after refill");
    report_test("flush");

    base = answer_count;
    fork
      random_fetches(0, 16);
      random_fetches(1, 16);
    join
    assert (answer_count - base == 32) else begin
      $display("[FAIL] %0t: %0d answer pulses for 32 mixed fetches", $time,
               answer_count - base);
      err_count++;
    end
    report_test("mixed traffic on both ports");

    $display("Done: %0d tests, %0d fetches, %0d memory requests, %0d errors",
             test_num, fetch_count, mem_req_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
